// File: src/memoryGame_macros.svh
//--------------------------------------------------
// Sizes and timer lengths for the memory game.
// DISPLAY_TICKS and REPLY_TICKS must be even, ROUNDS a power of two.
//--------------------------------------------------
`ifndef MEMORYGAME_MACROS_SVH
`define MEMORYGAME_MACROS_SVH

// Sequence memory geometry
`define ADDR_BITS     3
`define ROUNDS        8

// One bit per LED and per button
`define SYMBOL_BITS   4

// Cycles in one display period, middle flag at half
`define DISPLAY_TICKS 8

// Reply timeout at the long level, the short level uses half
`define REPLY_TICKS   64

`endif

// File: src/controlPkg.sv
//--------------------------------------------------
// Controller state and the strobe/status bundles
// between controller and datapath.
//--------------------------------------------------
package controlPkg;

    typedef enum logic [4:0] {
        idle        = 5'h00,
        setup       = 5'h01,
        roundStart  = 5'h02,
        show        = 5'h03,
        showWait    = 5'h04,
        showNext    = 5'h05,
        replyStart  = 5'h06,
        replyWait   = 5'h07,
        capture     = 5'h08,
        compare     = 5'h09,
        won         = 5'h0A,
        nextReply   = 5'h0B,
        recordWrite = 5'h0C,
        showBlank   = 5'h0D,
        lost        = 5'h0E,
        timedOut    = 5'h0F,
        recordWait  = 5'h10,
        recordStep  = 5'h11,
        recordShow  = 5'h12,
        nextRound   = 5'h13
    } gameState;

    // Commands from the controller, all decoded from state
    typedef struct packed {
        logic clearAddress;
        logic countAddress;
        logic clearRound;
        logic countRound;
        logic clearDisplay;
        logic runDisplay;
        logic clearReply;
        logic runReply;
        logic capturePlay;
        logic clearPlay;
        logic latchLevels;
        logic writeMemory;
    } controlStrobes;

    // Timer fields come from gameTimers, the rest from sequenceMemory
    typedef struct packed {
        logic displayMid;
        logic displayEnd;
        logic replyMid;
        logic replyEnd;
        logic replyExpired;
        logic addressAtRound;
        logic roundsHalf;
        logic roundsFull;
        logic roundsDone;
        logic pressed;
        logic playCorrect;
        logic recordMode;
    } statusFlags;

endpackage

// File: src/playPkg.sv
//--------------------------------------------------
// Player-facing types: symbols, levels and outputs.
//--------------------------------------------------
`include "memoryGame_macros.svh"

package playPkg;

    // One-hot symbol, one bit per LED or button
    typedef logic [`SYMBOL_BITS-1:0] symbol;

    // Short game stops at half the rounds
    typedef enum logic {
        shortGame = 1'b0,
        fullGame  = 1'b1
    } roundLevel;

    // Short reply times out at the middle flag
    typedef enum logic {
        longReply  = 1'b0,
        shortReply = 1'b1
    } timeLevel;

    typedef struct packed {
        logic showMemory;
        logic showPlay;
        logic beep;
        logic won;
        logic lost;
        logic ready;
        logic playerTurn;
        logic newPlay;
        logic timedOut;
    } playerView;

endpackage

// File: src/gameTimers.sv
//--------------------------------------------------
// Display period timer (wraps) and reply timeout (saturates).
// Clears win over run; flags are valid in the matching cycle.
//--------------------------------------------------
`include "memoryGame_macros.svh"

module gameTimers
    import controlPkg::*, playPkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  controlStrobes strobes,
    input  timeLevel      replyLevel,
    output statusFlags    flags
);

    localparam int displayBits = $clog2(`DISPLAY_TICKS);
    localparam int replyBits   = $clog2(`REPLY_TICKS);

    logic [displayBits-1:0] displayCount;
    logic [replyBits-1:0]   replyCount;
    logic                   displayMid;
    logic                   displayEnd;
    logic                   replyMid;
    logic                   replyEnd;

    //--------------------------------------------------
    // Counters
    //--------------------------------------------------
    // Display count restarts after the end so showBlank can wait a half period
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            displayCount <= '0;
        end else if (strobes.clearDisplay) begin
            displayCount <= '0;
        end else if (strobes.runDisplay) begin
            displayCount <= displayEnd ? '0 : displayCount + 1'b1;
        end
    end

    // Holds at the last tick until cleared
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            replyCount <= '0;
        end else if (strobes.clearReply) begin
            replyCount <= '0;
        end else if (strobes.runReply && !replyEnd) begin
            replyCount <= replyCount + 1'b1;
        end
    end

    //--------------------------------------------------
    // Flags
    //--------------------------------------------------
    assign displayMid = (displayCount == displayBits'(`DISPLAY_TICKS / 2 - 1));
    assign displayEnd = (displayCount == displayBits'(`DISPLAY_TICKS - 1));
    assign replyMid   = (replyCount == replyBits'(`REPLY_TICKS / 2 - 1));
    assign replyEnd   = (replyCount == replyBits'(`REPLY_TICKS - 1));

    always_comb begin
        flags              = '0;
        flags.displayMid   = displayMid;
        flags.displayEnd   = displayEnd;
        flags.replyMid     = replyMid;
        flags.replyEnd     = replyEnd;
        // Selected by the level latched at setup
        flags.replyExpired = (replyLevel == shortReply) ? replyMid : replyEnd;
    end

endmodule

// File: src/sequenceMemory.sv
//--------------------------------------------------
// Counters, sequence memory and play register. Buttons are
// assumed synchronous; reset loads entry i with bit (i mod 4).
//--------------------------------------------------
`include "memoryGame_macros.svh"

module sequenceMemory
    import controlPkg::*, playPkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  controlStrobes strobes,
    input  symbol         buttons,
    input  roundLevel     roundSelect,
    input  timeLevel      timeSelect,
    input  logic          recordMode,
    input  logic          showMemory,
    input  logic          showPlay,
    output symbol         leds,
    output timeLevel      replyLevel,
    output statusFlags    flags
);

    logic [`ADDR_BITS-1:0] address;
    logic [`ADDR_BITS-1:0] round;
    symbol                 memory [`ROUNDS];
    symbol                 play;
    roundLevel             roundLatched;
    logic                  recordLatched;
    logic                  anyHeld;

    //--------------------------------------------------
    // Counters and level latches
    //--------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            address       <= '0;
            round         <= '0;
            roundLatched  <= shortGame;
            replyLevel    <= longReply;
            recordLatched <= 1'b0;
            anyHeld       <= 1'b0;
        end else begin
            if (strobes.clearAddress) begin
                address <= '0;
            end else if (strobes.countAddress) begin
                address <= address + 1'b1;
            end
            if (strobes.clearRound) begin
                round <= '0;
            end else if (strobes.countRound) begin
                round <= round + 1'b1;
            end
            if (strobes.latchLevels) begin
                roundLatched  <= roundSelect;
                replyLevel    <= timeSelect;
                recordLatched <= recordMode;
            end
            anyHeld <= |buttons;
        end
    end

    // Sequence memory, fixed pattern after reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `ROUNDS; i++) begin
                memory[i] <= symbol'(1 << (i % `SYMBOL_BITS));
            end
        end else if (strobes.writeMemory) begin
            memory[address] <= buttons;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            play <= '0;
        end else if (strobes.clearPlay) begin
            play <= '0;
        end else if (strobes.capturePlay) begin
            play <= buttons;
        end
    end

    //--------------------------------------------------
    // Outputs
    //--------------------------------------------------
    assign leds = showMemory ? memory[address] : (showPlay ? play : '0);

    always_comb begin
        flags                = '0;
        flags.addressAtRound = (address == round);
        flags.roundsHalf     = (round == `ADDR_BITS'(`ROUNDS / 2 - 1));
        flags.roundsFull     = (round == `ADDR_BITS'(`ROUNDS - 1));
        flags.roundsDone     = (roundLatched == shortGame) ? flags.roundsHalf
                                                           : flags.roundsFull;
        // First cycle of a press only
        flags.pressed        = (|buttons) && !anyHeld;
        flags.playCorrect    = (play == memory[address]);
        flags.recordMode     = recordLatched;
    end

endmodule

// File: src/gameController.sv
//--------------------------------------------------
// Moore FSM of the memory game. Outputs depend on the
// current state only; levels arrive pre-selected in status.
//--------------------------------------------------
module gameController
    import controlPkg::*, playPkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          start,
    input  statusFlags    status,
    output controlStrobes strobes,
    output playerView     view,
    output gameState      stateCode
);

    gameState state;
    gameState nextState;

    assign stateCode = state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    //--------------------------------------------------
    // Next state
    //--------------------------------------------------
    always_comb begin
        nextState = state;
        unique case (state)
            idle:        if (start) nextState = setup;
            setup:       nextState = roundStart;
            roundStart:  if (status.displayMid) nextState = show;
            show:        nextState = showWait;
            showWait: begin
                if (status.displayEnd) begin
                    nextState = status.addressAtRound ? replyStart : showBlank;
                end
            end
            showBlank:   if (status.displayMid) nextState = showNext;
            showNext:    nextState = show;
            replyStart:  nextState = replyWait;
            replyWait: begin
                // Timeout wins over a press in the same cycle
                if (status.replyExpired) begin
                    nextState = timedOut;
                end else if (status.pressed) begin
                    nextState = capture;
                end
            end
            capture:     nextState = compare;
            compare: begin
                if (status.displayMid) begin
                    if (!status.playCorrect) begin
                        nextState = lost;
                    end else if (!status.addressAtRound) begin
                        nextState = nextReply;
                    end else if (status.roundsDone) begin
                        nextState = won;
                    end else begin
                        nextState = status.recordMode ? recordStep : nextRound;
                    end
                end
            end
            nextReply:   nextState = replyWait;
            nextRound:   nextState = roundStart;
            recordStep:  nextState = recordWait;
            recordWait:  if (status.pressed) nextState = recordWrite;
            recordWrite: nextState = recordShow;
            recordShow:  if (status.displayMid) nextState = replyStart;
            won, lost, timedOut: begin
                if (start) nextState = setup;
            end
            default:     nextState = idle;
        endcase
    end

    //--------------------------------------------------
    // Moore outputs
    //--------------------------------------------------
    always_comb begin
        strobes = '0;
        view    = '0;
        unique case (state)
            setup: begin
                strobes.clearRound   = 1'b1;
                strobes.clearDisplay = 1'b1;
                strobes.clearReply   = 1'b1;
                strobes.clearPlay    = 1'b1;
                strobes.latchLevels  = 1'b1;
            end
            roundStart: begin
                strobes.clearAddress = 1'b1;
                strobes.runDisplay   = 1'b1;
            end
            show: begin
                strobes.clearDisplay = 1'b1;
            end
            showWait: begin
                strobes.runDisplay = 1'b1;
                view.showMemory    = 1'b1;
                view.beep          = 1'b1;
            end
            showBlank: begin
                strobes.runDisplay = 1'b1;
            end
            showNext: begin
                strobes.countAddress = 1'b1;
            end
            replyStart: begin
                strobes.clearAddress = 1'b1;
                strobes.clearDisplay = 1'b1;
                strobes.clearReply   = 1'b1;
            end
            replyWait: begin
                strobes.runReply = 1'b1;
                view.playerTurn  = 1'b1;
            end
            capture: begin
                strobes.capturePlay  = 1'b1;
                strobes.clearDisplay = 1'b1;
            end
            compare: begin
                strobes.runDisplay = 1'b1;
                view.showPlay      = 1'b1;
                view.beep          = 1'b1;
            end
            nextReply: begin
                strobes.countAddress = 1'b1;
                strobes.clearDisplay = 1'b1;
                strobes.clearReply   = 1'b1;
            end
            nextRound: begin
                strobes.countRound   = 1'b1;
                strobes.clearDisplay = 1'b1;
            end
            // New entry goes one past the last address of the round
            recordStep: begin
                strobes.countAddress = 1'b1;
            end
            recordWait: begin
                view.newPlay = 1'b1;
            end
            recordWrite: begin
                strobes.writeMemory  = 1'b1;
                strobes.capturePlay  = 1'b1;
                strobes.countRound   = 1'b1;
                strobes.clearDisplay = 1'b1;
            end
            recordShow: begin
                strobes.runDisplay = 1'b1;
                view.showMemory    = 1'b1;
                view.beep          = 1'b1;
            end
            won: begin
                view.won   = 1'b1;
                view.ready = 1'b1;
            end
            lost: begin
                view.lost  = 1'b1;
                view.ready = 1'b1;
            end
            timedOut: begin
                view.lost     = 1'b1;
                view.timedOut = 1'b1;
                view.ready    = 1'b1;
            end
            default: begin
                strobes = '0;
            end
        endcase
    end

endmodule

// File: src/memoryGame.sv
//--------------------------------------------------
// Memory game top. Status bundles from the timers and the
// datapath are merged by OR, each drives its own fields.
//--------------------------------------------------
module memoryGame
    import controlPkg::*, playPkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      start,
    input  symbol     buttons,
    input  roundLevel roundSelect,
    input  timeLevel  timeSelect,
    input  logic      recordMode,
    output symbol     leds,
    output playerView view,
    output gameState  stateCode
);

    controlStrobes strobes;
    statusFlags    status;
    statusFlags    timerFlags;
    statusFlags    dataFlags;
    timeLevel      replyLevel;

    assign status = timerFlags | dataFlags;

    gameController controller (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .status    (status),
        .strobes   (strobes),
        .view      (view),
        .stateCode (stateCode)
    );

    gameTimers timers (
        .clock      (clock),
        .reset      (reset),
        .strobes    (strobes),
        .replyLevel (replyLevel),
        .flags      (timerFlags)
    );

    sequenceMemory datapath (
        .clock       (clock),
        .reset       (reset),
        .strobes     (strobes),
        .buttons     (buttons),
        .roundSelect (roundSelect),
        .timeSelect  (timeSelect),
        .recordMode  (recordMode),
        .showMemory  (view.showMemory),
        .showPlay    (view.showPlay),
        .leds        (leds),
        .replyLevel  (replyLevel),
        .flags       (dataFlags)
    );

endmodule

// File: bench/memoryGameAsserts.sv
//--------------------------------------------------
// Controller checks, bound into gameController.
// All checks are off while reset is high.
//--------------------------------------------------
module memoryGameAsserts
    import controlPkg::*, playPkg::*;
(
    input logic          clock,
    input logic          reset,
    input statusFlags    status,
    input controlStrobes strobes,
    input playerView     view,
    input gameState      state
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // End states are exclusive
    assert property (@(posedge clock) disable iff (reset)
        !(view.won && view.lost))
    else begin
        failures++;
        $error("won and lost are both high");
    end

    assert property (@(posedge clock) disable iff (reset)
        view.ready == (view.won || view.lost))
    else begin
        failures++;
        $error("ready does not match won or lost");
    end

    // Reply timer starts from a clear and runs for the whole player turn
    assert property (@(posedge clock) disable iff (reset)
        view.playerTurn |-> strobes.runReply
                            && ($past(strobes.clearReply) || $past(view.playerTurn)))
    else begin
        failures++;
        $error("playerTurn high without a freshly started reply timer");
    end

    // A write needs a press seen while waiting for a new symbol
    assert property (@(posedge clock) disable iff (reset)
        strobes.writeMemory |-> $past(status.pressed) && ($past(state) == recordWait))
    else begin
        failures++;
        $error("writeMemory without a press in recordWait");
    end

endmodule

bind gameController memoryGameAsserts assertions (
    .clock   (clock),
    .reset   (reset),
    .status  (status),
    .strobes (strobes),
    .view    (view),
    .state   (state)
);

// File: bench/memoryGameBench.sv
//--------------------------------------------------
// Table-driven testbench for the memory game. Sequence memory is
// only reset once, so recorded symbols carry over to later rows.
//--------------------------------------------------
`include "memoryGame_macros.svh"

module memoryGameBench
    import controlPkg::*, playPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {expectWon, expectLost, expectTimeout} outcome;

    // One game: levels, player faults, symbols to record, result
    typedef struct packed {
        roundLevel                            rounds;
        timeLevel                             reply;
        logic                                 record;
        logic [3:0]                           errRound;
        logic [3:0]                           silentRound;
        logic [`ROUNDS-1:0][`SYMBOL_BITS-1:0] records;
        outcome                               expected;
    } scenario;

    localparam int         rowCount       = 7;
    localparam logic [3:0] noRound        = 4'hF;
    localparam int         cyclesPerRow   = `ROUNDS * `ROUNDS * 2 * `DISPLAY_TICKS
                                            + `ROUNDS * `REPLY_TICKS;
    localparam int         watchdogCycles = rowCount * cyclesPerRow + 8;

    logic      clock = 1'b0;
    logic      reset;
    logic      start;
    symbol     buttons;
    roundLevel roundSelect;
    timeLevel  timeSelect;
    logic      recordMode;
    symbol     leds;
    playerView view;
    gameState  stateCode;

    scenario scenarios [rowCount];
    symbol   expectedMemory [`ROUNDS];
    int      errorCount;
    int      checkCount;
    int      showIndex;
    int      recordAddress;
    logic    recordShowPending;
    logic    showSeen;

    memoryGame uut (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .buttons     (buttons),
        .roundSelect (roundSelect),
        .timeSelect  (timeSelect),
        .recordMode  (recordMode),
        .leds        (leds),
        .view        (view),
        .stateCode   (stateCode)
    );

    always #10 clock = ~clock;

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // Hold a symbol for three cycles, then a short random gap
    task automatic pressButtons(input symbol value);
        int gap;
        @(posedge clock);
        buttons <= value;
        repeat (3) @(posedge clock);
        buttons <= '0;
        gap = $urandom_range(3, 1);
        repeat (gap) @(posedge clock);
    endtask

    //--------------------------------------------------
    // Display monitor, one check per lit symbol
    //--------------------------------------------------
    always @(negedge clock) begin
        if (!reset && view.showMemory && !showSeen) begin
            if (recordShowPending) begin
                checkValue("leds (new symbol)", leds, expectedMemory[recordAddress]);
                recordShowPending = 1'b0;
            end else begin
                checkValue("leds", leds, expectedMemory[showIndex]);
                showIndex++;
            end
        end
        showSeen = view.showMemory;
    end

    task automatic playGame(input scenario row);
        int    rounds;
        int    roundNow;
        int    replyIndex;
        int    quietCycles;
        int    newPlays;
        logic  silent;
        symbol target;
        rounds      = (row.rounds == shortGame) ? `ROUNDS / 2 : `ROUNDS;
        roundNow    = 0;
        replyIndex  = 0;
        quietCycles = 0;
        newPlays    = 0;
        silent      = 1'b0;
        showIndex   = 0;
        @(posedge clock);
        roundSelect <= row.rounds;
        timeSelect  <= row.reply;
        recordMode  <= row.record;
        start       <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        forever begin
            @(negedge clock);
            if (silent) quietCycles++;
            if (view.ready) break;
            if (view.newPlay) begin
                newPlays++;
                expectedMemory[roundNow] = row.records[roundNow];
                recordAddress            = roundNow;
                recordShowPending        = 1'b1;
                pressButtons(row.records[roundNow]);
            end else if (view.playerTurn && !silent) begin
                if (replyIndex == 0) begin
                    checkValue("symbols shown", showIndex,
                               (row.record && roundNow > 0) ? 0 : roundNow + 1);
                end
                if (roundNow == row.silentRound && replyIndex == 0) begin
                    silent = 1'b1;
                end else begin
                    target = expectedMemory[replyIndex];
                    if (roundNow == row.errRound && replyIndex == roundNow) begin
                        // Any other one-hot symbol is wrong
                        target = {target[`SYMBOL_BITS-2:0], target[`SYMBOL_BITS-1]};
                    end else if (replyIndex == roundNow) begin
                        roundNow++;
                        replyIndex = 0;
                        showIndex  = 0;
                    end else begin
                        replyIndex++;
                    end
                    pressButtons(target);
                end
            end
        end
        // End state must hold until the next start
        @(negedge clock);
        checkValue("view.ready", view.ready, 1'b1);
        checkValue("newPlay count", newPlays, row.record ? rounds - 1 : 0);
        case (row.expected)
            expectWon: begin
                checkValue("view.won", view.won, 1'b1);
                checkValue("view.lost", view.lost, 1'b0);
                checkValue("rounds played", roundNow, rounds);
            end
            expectLost: begin
                checkValue("view.won", view.won, 1'b0);
                checkValue("view.lost", view.lost, 1'b1);
                checkValue("view.timedOut", view.timedOut, 1'b0);
                checkValue("rounds played", roundNow, row.errRound);
            end
            default: begin
                checkValue("view.won", view.won, 1'b0);
                checkValue("view.lost", view.lost, 1'b1);
                checkValue("view.timedOut", view.timedOut, 1'b1);
                if (row.reply == shortReply) begin
                    checkValue("short timeout in time", quietCycles < `REPLY_TICKS, 1'b1);
                end else begin
                    checkValue("long timeout late", quietCycles > `REPLY_TICKS / 2, 1'b1);
                end
            end
        endcase
    endtask

    //--------------------------------------------------
    // Main sequence
    //--------------------------------------------------
    initial begin
        void'($urandom(31182));
        reset             = 1'b1;
        start             = 1'b0;
        buttons           = '0;
        roundSelect       = shortGame;
        timeSelect        = longReply;
        recordMode        = 1'b0;
        errorCount        = 0;
        checkCount        = 0;
        showIndex         = 0;
        recordAddress     = 0;
        recordShowPending = 1'b0;
        showSeen          = 1'b0;
        // Power-up pattern, entry i lights LED (i mod 4)
        for (int i = 0; i < `ROUNDS; i++) begin
            expectedMemory[i]                   = '0;
            expectedMemory[i][i % `SYMBOL_BITS] = 1'b1;
        end
        scenarios[0] = '{fullGame, longReply, 1'b0, noRound, noRound, '0, expectWon};
        scenarios[1] = '{shortGame, shortReply, 1'b0, noRound, noRound, '0, expectWon};
        scenarios[2] = '{fullGame, longReply, 1'b0, 4'd2, noRound, '0, expectLost};
        scenarios[3] = '{shortGame, shortReply, 1'b0, noRound, 4'd1, '0, expectTimeout};
        scenarios[4] = '{fullGame, longReply, 1'b0, noRound, 4'd0, '0, expectTimeout};
        scenarios[5] = '{shortGame, longReply, 1'b1, noRound, noRound, 32'h8412_2180,
                         expectWon};
        scenarios[6] = '{fullGame, shortReply, 1'b1, noRound, noRound, 32'h1824_4810,
                         expectWon};

        repeat (7) @(posedge clock);
        @(negedge clock);
        checkValue("view (reset)", view, '0);
        checkValue("leds (reset)", leds, '0);
        checkValue("stateCode (reset)", stateCode, idle);
        @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        checkValue("view (idle)", view, '0);
        checkValue("leds (idle)", leds, '0);
        checkValue("stateCode (idle)", stateCode, idle);

        for (int row = 0; row < rowCount; row++) begin
            playGame(scenarios[row]);
        end

        errorCount += uut.controller.assertions.failures;
        $display("Checks run: %0d, errors: %0d (assertion failures: %0d)",
                 checkCount, errorCount, uut.controller.assertions.failures);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Bound on the longest table, reset included
    initial begin
        repeat (watchdogCycles) @(posedge clock);
        $display("Watchdog expired: the games did not end within %0d cycles", watchdogCycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: memoryGame.f
+incdir+src
src/controlPkg.sv
src/playPkg.sv
src/gameTimers.sv
src/sequenceMemory.sv
src/gameController.sv
src/memoryGame.sv
bench/memoryGameAsserts.sv
bench/memoryGameBench.sv

// File: Bender.yml
package:
  name: memoryGame

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/controlPkg.sv
      - src/playPkg.sv
      - src/gameTimers.sv
      - src/sequenceMemory.sv
      - src/gameController.sv
      - src/memoryGame.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/memoryGameAsserts.sv
      - bench/memoryGameBench.sv
